//--- verilog/forward_pkt_pkg.sv
/*
 * Forward-data engine packet format
 * Field widths and the packet struct shared by both input streams and the output
 */

package forward_pkt_pkg;

    // ------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------
    localparam int ENGINE_ID_W = 8;
    localparam int SEQ_W       = 16;
    localparam int DATA_W      = 32;

    // ------------------------------------------------------------
    // Field types
    // ------------------------------------------------------------
    // Engine id as packet source or destination
    typedef logic [ENGINE_ID_W-1:0] engine_id_t;

    // Sequence number, also reused as configuration field selector
    typedef logic [SEQ_W-1:0] seq_t;

    // One data word
    typedef logic [DATA_W-1:0] data_t;

    // ------------------------------------------------------------
    // Packet
    // ------------------------------------------------------------
    // A valid bit high for a single cycle is one strobe
    typedef struct packed {
        logic       valid;
        engine_id_t src_id;
        engine_id_t dst_id;
        seq_t       seq;
        data_t      data;
    } mem_packet_t;

endpackage : forward_pkt_pkg

//--- verilog/forward_cfg_pkg.sv
/*
 * Forward-data engine configuration
 * Configuration record, field selectors and generator FSM states
 */

package forward_cfg_pkg;

    import forward_pkt_pkg::*;

    // Number of packets to forward
    typedef logic [15:0] count_t;

    // Loaded from memory responses one field at a time
    typedef struct packed {
        engine_id_t dst_id;
        seq_t       seq_base;
        count_t     packet_count;
    } fwd_config_t;

    // ------------------------------------------------------------
    // Field selectors carried in the seq field
    // ------------------------------------------------------------
    localparam seq_t CFG_SEL_DST      = 16'd0;
    localparam seq_t CFG_SEL_SEQ_BASE = 16'd1;
    localparam seq_t CFG_SEL_COUNT    = 16'd2;

    // Generator FSM
    typedef enum logic [1:0] {
        gen_wait_cfg,
        gen_run,
        gen_done
    } gen_state_t;

endpackage : forward_cfg_pkg

//--- verilog/forward_config_store.sv
/*
 * Configuration store
 * Loads destination, sequence base and packet count from memory-response strobes
 */

`timescale 1ns/1ps

module forward_config_store
    import forward_pkt_pkg::*, forward_cfg_pkg::*;
(
    input  logic        ap_clk,
    input  logic        areset_csr_engine,
    input  mem_packet_t response_memory_in,
    output fwd_config_t cfg,
    output logic        cfg_ready
);

    mem_packet_t response_memory_in_reg;

    logic       load_dst;
    logic       load_seq_base;
    logic       load_count;
    logic [2:0] loaded;
    logic [2:0] loaded_next;

    // ------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        response_memory_in_reg <= response_memory_in;
        if (areset_csr_engine) begin
            response_memory_in_reg.valid <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Field select decode
    // ------------------------------------------------------------
    // Selectors above 2 match nothing and are dropped
    assign load_dst      = response_memory_in_reg.valid &&
                           (response_memory_in_reg.seq == CFG_SEL_DST);
    assign load_seq_base = response_memory_in_reg.valid &&
                           (response_memory_in_reg.seq == CFG_SEL_SEQ_BASE);
    assign load_count    = response_memory_in_reg.valid &&
                           (response_memory_in_reg.seq == CFG_SEL_COUNT);

    assign loaded_next = loaded | {load_count, load_seq_base, load_dst};

    // Loaded flags, ready tracks the flags in the same cycle
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            loaded    <= 3'b000;
            cfg_ready <= 1'b0;
        end else begin
            loaded    <= loaded_next;
            cfg_ready <= &loaded_next;
        end
    end

    // Field values, a later strobe overwrites
    always_ff @(posedge ap_clk) begin
        if (load_dst) begin
            cfg.dst_id <= response_memory_in_reg.data[ENGINE_ID_W-1:0];
        end
        if (load_seq_base) begin
            cfg.seq_base <= response_memory_in_reg.data[SEQ_W-1:0];
        end
        if (load_count) begin
            cfg.packet_count <= response_memory_in_reg.data[$bits(count_t)-1:0];
        end
    end

endmodule : forward_config_store

//--- verilog/forward_response_queue.sv
/*
 * Engine-response queue
 * Circular buffer holding data words until the generator pops them
 */

`timescale 1ns/1ps

module forward_response_queue
    import forward_pkt_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic        ap_clk,
    input  logic        areset_csr_engine,
    input  mem_packet_t response_engine_in,
    input  logic        pop,
    output data_t       head,
    output logic        queue_empty
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   occ_t;

    logic  in_valid;
    data_t in_data;

    data_t buffer [QUEUE_DEPTH];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    occ_t  occupancy;
    logic  full;
    logic  push;

    // ------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------
    // Only the data word of an engine response is kept
    always_ff @(posedge ap_clk) begin
        in_data <= response_engine_in.data;
        if (areset_csr_engine) begin
            in_valid <= 1'b0;
        end else begin
            in_valid <= response_engine_in.valid;
        end
    end

    // ------------------------------------------------------------
    // Buffer
    // ------------------------------------------------------------
    assign full        = (occupancy == occ_t'(QUEUE_DEPTH));
    assign queue_empty = (occupancy == '0);
    assign push        = in_valid && !full;
    assign head        = buffer[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (push) begin
            buffer[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   occupancy <= occupancy + occ_t'(1);
                2'b01:   occupancy <= occupancy - occ_t'(1);
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule : forward_response_queue

//--- verilog/forward_generator.sv
/*
 * Request generator
 * Pops queued words once configured and issues stamped engine requests
 */

`timescale 1ns/1ps

module forward_generator
    import forward_pkt_pkg::*, forward_cfg_pkg::*;
#(
    parameter int ENGINE_ID = 5
) (
    input  logic        ap_clk,
    input  logic        areset_csr_engine,
    input  fwd_config_t cfg,
    input  logic        cfg_ready,
    input  data_t       head,
    input  logic        queue_empty,
    output logic        pop,
    output mem_packet_t request_engine_out,
    output logic        done_out
);

    gen_state_t state;
    gen_state_t state_next;
    count_t     pop_count;
    logic       last_pop;

    // ------------------------------------------------------------
    // Pop control
    // ------------------------------------------------------------
    assign pop      = (state == gen_run) && !queue_empty;
    assign last_pop = pop && ((pop_count + count_t'(1)) == cfg.packet_count);

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            gen_wait_cfg: begin
                if (cfg_ready) begin
                    // Nothing to forward with a zero count
                    if (cfg.packet_count == '0) begin
                        state_next = gen_done;
                    end else begin
                        state_next = gen_run;
                    end
                end
            end
            gen_run: begin
                if (last_pop) begin
                    state_next = gen_done;
                end
            end
            gen_done: begin
                state_next = gen_done;
            end
            default: begin
                state_next = gen_wait_cfg;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state     <= gen_wait_cfg;
            pop_count <= '0;
            done_out  <= 1'b0;
        end else begin
            state    <= state_next;
            done_out <= (state == gen_done);
            if (pop) begin
                pop_count <= pop_count + count_t'(1);
            end
        end
    end

    // ------------------------------------------------------------
    // Request register
    // ------------------------------------------------------------
    // Seq wraps at 16 bits, pop_count equals the number of earlier requests
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            request_engine_out.valid <= 1'b0;
        end else begin
            request_engine_out.valid <= pop;
        end
        if (pop) begin
            request_engine_out.src_id <= engine_id_t'(ENGINE_ID);
            request_engine_out.dst_id <= cfg.dst_id;
            request_engine_out.seq    <= cfg.seq_base + seq_t'(pop_count);
            request_engine_out.data   <= head;
        end
    end

endmodule : forward_generator

//--- verilog/forward_data_top.sv
/*
 * Forward-data engine top level
 * Config store and response queue feed the request generator
 */

`timescale 1ns/1ps

module forward_data_top
    import forward_pkt_pkg::*, forward_cfg_pkg::*;
#(
    parameter int ENGINE_ID   = 5,
    parameter int QUEUE_DEPTH = 16
) (
    input  logic        ap_clk,
    input  logic        areset_csr_engine,
    input  mem_packet_t response_memory_in,
    input  mem_packet_t response_engine_in,
    output mem_packet_t request_engine_out,
    output logic        done_out
);

    fwd_config_t cfg;
    logic        cfg_ready;
    data_t       head;
    logic        queue_empty;
    logic        pop;

    // ------------------------------------------------------------
    // Configuration from memory responses
    // ------------------------------------------------------------
    forward_config_store inst_config_store (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .response_memory_in(response_memory_in),
        .cfg               (cfg),
        .cfg_ready         (cfg_ready)
    );

    // ------------------------------------------------------------
    // Data words from engine responses
    // ------------------------------------------------------------
    forward_response_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) inst_response_queue (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .response_engine_in(response_engine_in),
        .pop               (pop),
        .head              (head),
        .queue_empty       (queue_empty)
    );

    // Requests leave in arrival order
    forward_generator #(
        .ENGINE_ID(ENGINE_ID)
    ) inst_generator (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .cfg               (cfg),
        .cfg_ready         (cfg_ready),
        .head              (head),
        .queue_empty       (queue_empty),
        .pop               (pop),
        .request_engine_out(request_engine_out),
        .done_out          (done_out)
    );

endmodule : forward_data_top

//--- verif/tb_forward_data.sv
/*
 * Forward-data engine testbench
 * Replays the golden file tests and checks every engine request against it
 */

`timescale 1ns/1ps

module tb_forward_data
    import forward_pkt_pkg::*, forward_cfg_pkg::*;
();

    localparam int MAX_TESTS         = 16;
    localparam int MAX_WORDS         = 256;
    localparam int MODE_DATA_FIRST   = 1;
    localparam int MODE_BACK_TO_BACK = 2;
    localparam int CYCLES_PER_WORD   = 40;
    localparam int CYCLES_PER_TEST   = 100;
    localparam int TAIL_CYCLES       = 20;
    localparam logic [31:0] LFSR_SEED = 32'd98356;

    logic        ap_clk;
    logic        areset_csr_engine;
    mem_packet_t response_memory_in;
    mem_packet_t response_engine_in;
    mem_packet_t request_engine_out;
    logic        done_out;

    // Golden tests
    int          test_count;
    int          word_total;
    int          extra_total;
    int          test_num    [MAX_TESTS];
    int          test_mode   [MAX_TESTS];
    data_t       cfg_dst     [MAX_TESTS];
    data_t       cfg_base    [MAX_TESTS];
    data_t       cfg_count   [MAX_TESTS];
    int          word_start  [MAX_TESTS];
    int          word_n      [MAX_TESTS];
    int          extra_start [MAX_TESTS];
    int          extra_n     [MAX_TESTS];
    data_t       word_data   [MAX_WORDS];
    logic [31:0] exp_dst     [MAX_WORDS];
    logic [31:0] exp_src     [MAX_WORDS];
    logic [31:0] exp_seq     [MAX_WORDS];
    data_t       extra_data  [MAX_WORDS];

    // Run state shared by the driver and the monitor
    int          cur_test;
    int          cur_count;
    int          seen_count;
    logic        monitor_on;
    logic        config_sent;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;
    int          timeout_limit;
    logic [31:0] lfsr_state;

    forward_data_top UUT (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .response_memory_in(response_memory_in),
        .response_engine_in(response_engine_in),
        .request_engine_out(request_engine_out),
        .done_out          (done_out)
    );

    always #2 ap_clk = ~ap_clk;

    // Whole-run limit set once the golden file is loaded
    always @(posedge ap_clk) begin
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("ERROR: simulation timed out waiting for requests");
            $display("=== FAIL ===");
            $finish;
        end else begin
            cycle_count = cycle_count + 1;
        end
    end

    // ------------------------------------------------------------
    // Reporting and random gaps
    // ------------------------------------------------------------
    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("FAIL t=%0t test %0d request %0d: %s got %h expected %h",
                 $time, test_num[cur_test], seen_count, field, got, expected);
        error_count = error_count + 1;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR: t=%0t test %0d: %s", $time, test_num[cur_test], msg);
        error_count = error_count + 1;
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_gap(output int gap);
        gap = 0;
        lfsr_state = lfsr_next(lfsr_state);
        if (lfsr_state[0]) gap = gap + 2;
        lfsr_state = lfsr_next(lfsr_state);
        if (lfsr_state[0]) gap = gap + 1;
    endtask

    // ------------------------------------------------------------
    // Golden file
    // ------------------------------------------------------------
    task automatic load_golden(output int ok);
        int          fd;
        int          code;
        int          num;
        int          mode;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        string       line;
        ok = 0;
        fd = $fopen("verif/forward_golden.txt", "r");
        if (fd != 0) begin
            ok = 1;
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    if (line.getc(0) == "T") begin
                        code = $sscanf(line, "T %d %d %h %h %h", num, mode, a, b, c);
                        test_num[test_count]    = num;
                        test_mode[test_count]   = mode;
                        cfg_dst[test_count]     = a;
                        cfg_base[test_count]    = b;
                        cfg_count[test_count]   = c;
                        word_start[test_count]  = word_total;
                        word_n[test_count]      = 0;
                        extra_start[test_count] = extra_total;
                        extra_n[test_count]     = 0;
                        test_count = test_count + 1;
                    end else if (line.getc(0) == "W") begin
                        code = $sscanf(line, "W %h %h %h %h", a, b, c, d);
                        word_data[word_total] = a;
                        exp_dst[word_total]   = b;
                        exp_src[word_total]   = c;
                        exp_seq[word_total]   = d;
                        word_total = word_total + 1;
                        word_n[test_count-1] = word_n[test_count-1] + 1;
                    end else if (line.getc(0) == "X") begin
                        code = $sscanf(line, "X %h", a);
                        extra_data[extra_total] = a;
                        extra_total = extra_total + 1;
                        extra_n[test_count-1] = extra_n[test_count-1] + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------
    task automatic apply_reset();
        @(posedge ap_clk);
        areset_csr_engine  <= 1'b1;
        response_memory_in <= '0;
        response_engine_in <= '0;
        repeat (8) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge ap_clk);
            response_memory_in <= '0;
            response_engine_in <= '0;
        end
    endtask

    task automatic wait_gap(input int mode);
        int gap;
        if (mode != MODE_BACK_TO_BACK) begin
            random_gap(gap);
            idle_cycles(gap);
        end
    endtask

    task automatic drive_memory_strobe(input seq_t sel, input data_t value);
        mem_packet_t pkt;
        pkt       = '0;
        pkt.valid = 1'b1;
        pkt.seq   = sel;
        pkt.data  = value;
        @(posedge ap_clk);
        response_memory_in <= pkt;
        response_engine_in <= '0;
    endtask

    task automatic drive_engine_strobe(input data_t value);
        mem_packet_t pkt;
        pkt       = '0;
        pkt.valid = 1'b1;
        pkt.data  = value;
        @(posedge ap_clk);
        response_memory_in <= '0;
        response_engine_in <= pkt;
    endtask

    function automatic data_t config_value(input int t, input seq_t sel);
        case (sel)
            CFG_SEL_DST:      return cfg_dst[t];
            CFG_SEL_SEQ_BASE: return cfg_base[t];
            default:          return cfg_count[t];
        endcase
    endfunction

    // Shuffled order is count, destination, base
    task automatic send_config(input int t, input logic shuffled);
        seq_t sel;
        for (int i = 0; i < 3; i++) begin
            sel = shuffled ? seq_t'((i + 2) % 3) : seq_t'(i);
            drive_memory_strobe(sel, config_value(t, sel));
            if (i < 2) begin
                wait_gap(test_mode[t]);
            end
        end
        config_sent = 1'b1;
    endtask

    task automatic send_words(input int t);
        for (int i = 0; i < word_n[t]; i++) begin
            drive_engine_strobe(word_data[word_start[t] + i]);
            wait_gap(test_mode[t]);
        end
    endtask

    // ------------------------------------------------------------
    // Monitor
    // ------------------------------------------------------------
    always @(negedge ap_clk) begin
        int idx;
        if (monitor_on) begin
            if (done_out && seen_count < cur_count) begin
                report_problem("done_out rose before all requests were seen");
            end
            if (request_engine_out.valid) begin
                if (!config_sent) begin
                    report_problem("request seen before the configuration was complete");
                end
                if (seen_count >= cur_count) begin
                    report_problem("request seen beyond the expected count");
                end else begin
                    idx = word_start[cur_test] + seen_count;
                    if (32'(request_engine_out.dst_id) != exp_dst[idx]) begin
                        report_mismatch("dst_id", 32'(request_engine_out.dst_id), exp_dst[idx]);
                    end
                    if (32'(request_engine_out.src_id) != exp_src[idx]) begin
                        report_mismatch("src_id", 32'(request_engine_out.src_id), exp_src[idx]);
                    end
                    if (32'(request_engine_out.seq) != exp_seq[idx]) begin
                        report_mismatch("seq", 32'(request_engine_out.seq), exp_seq[idx]);
                    end
                    if (request_engine_out.data != word_data[idx]) begin
                        report_mismatch("data", request_engine_out.data, word_data[idx]);
                    end
                end
                seen_count = seen_count + 1;
            end
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    task automatic run_test(input int t);
        int errors_before;
        errors_before = error_count;
        apply_reset();
        @(negedge ap_clk);
        if (request_engine_out.valid || done_out) begin
            report_problem("outputs not idle after reset");
        end
        @(posedge ap_clk);
        cur_test    = t;
        cur_count   = word_n[t];
        seen_count  = 0;
        config_sent = 1'b0;
        monitor_on  = 1'b1;
        if (test_mode[t] == MODE_DATA_FIRST) begin
            send_words(t);
            idle_cycles(2);
            send_config(t, 1'b1);
        end else begin
            send_config(t, 1'b0);
            wait_gap(test_mode[t]);
            send_words(t);
        end
        idle_cycles(1);
        while (seen_count < cur_count) @(posedge ap_clk);
        // Done follows the last request by one cycle
        @(negedge ap_clk);
        if (!done_out) begin
            report_problem("done_out not high one cycle after the last request");
        end
        for (int i = 0; i < extra_n[t]; i++) begin
            drive_engine_strobe(extra_data[extra_start[t] + i]);
        end
        idle_cycles(1);
        repeat (TAIL_CYCLES) begin
            @(negedge ap_clk);
            if (!done_out) begin
                report_problem("done_out dropped after completion");
            end
        end
        @(posedge ap_clk);
        monitor_on = 1'b0;
        if (seen_count != int'(cfg_count[t])) begin
            report_problem("request count differs from packet_count");
        end
        if (error_count == errors_before) begin
            $display("test %0d mode %0d: passed, %0d requests", test_num[t], test_mode[t],
                     seen_count);
            tests_passed = tests_passed + 1;
        end else begin
            $display("test %0d mode %0d: failed with %0d errors", test_num[t], test_mode[t],
                     error_count - errors_before);
            tests_failed = tests_failed + 1;
        end
    endtask

    initial begin
        int ok;
        ap_clk             = 1'b0;
        areset_csr_engine  = 1'b1;
        response_memory_in = '0;
        response_engine_in = '0;
        monitor_on         = 1'b0;
        config_sent        = 1'b0;
        cur_test           = 0;
        cur_count          = 0;
        seen_count         = 0;
        error_count        = 0;
        tests_passed       = 0;
        tests_failed       = 0;
        cycle_count        = 0;
        timeout_limit      = 0;
        test_count         = 0;
        word_total         = 0;
        extra_total        = 0;
        lfsr_state         = LFSR_SEED;
        load_golden(ok);
        if (ok == 0 || test_count == 0) begin
            $display("ERROR: could not read any test from the golden file");
            $display("=== FAIL ===");
            $finish;
        end else begin
            timeout_limit = CYCLES_PER_WORD * (word_total + extra_total)
                          + CYCLES_PER_TEST * test_count;
            for (int t = 0; t < test_count; t++) begin
                run_test(t);
            end
            $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
            if (tests_failed == 0 && error_count == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule : tb_forward_data

//--- verif/forward_golden.txt
# T test mode dst seq_base count (hex) ; mode 0 config first, 1 data first, 2 back to back
# W data exp_dst exp_src exp_seq (hex) ; X extra data word sent after done
T 1 0 00000021 00000100 00000004
W a1000001 21 05 0100
W a1000002 21 05 0101
W a1000003 21 05 0102
W a1000004 21 05 0103
T 2 1 00000033 00000010 00000006
W b2000010 33 05 0010
W b2000011 33 05 0011
W 0badcafe 33 05 0012
W b2000013 33 05 0013
W ffffffff 33 05 0014
W 00000000 33 05 0015
T 3 0 00000044 00000200 00000003
W c3000001 44 05 0200
W c3000002 44 05 0201
W c3000003 44 05 0202
X c30000ff
X c30000fe
T 4 0 0000005a 0000fffe 00000004
W d4000001 5a 05 fffe
W d4000002 5a 05 ffff
W d4000003 5a 05 0000
W d4000004 5a 05 0001
T 5 1 0000007e 00000040 00000005
W e5000001 7e 05 0040
W 12345678 7e 05 0041
W e5000003 7e 05 0042
W 87654321 7e 05 0043
W e5000005 7e 05 0044
T 6 2 00000019 00001234 00000008
W f6000001 19 05 1234
W f6000002 19 05 1235
W f6000003 19 05 1236
W f6000004 19 05 1237
W f6000005 19 05 1238
W f6000006 19 05 1239
W f6000007 19 05 123a
W f6000008 19 05 123b

//--- tb.f
verilog/forward_pkt_pkg.sv
verilog/forward_cfg_pkg.sv
verilog/forward_config_store.sv
verilog/forward_response_queue.sv
verilog/forward_generator.sv
verilog/forward_data_top.sv
verif/tb_forward_data.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the forward-data engine testbench with Verilator, run it, check the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir_tb
LOG=sim.log
TOP=tb_forward_data

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -sv -f tb.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
